//--- src/sdr_bus_cfg.svh
`ifndef SDR_BUS_CFG_SVH
`define SDR_BUS_CFG_SVH

// Datapath widths
`define SDR_IQ_W 24
`define SDR_ADC_W 16
`define SDR_NCO_W 32

// Power-up values of the parameter registers
`define SDR_NCO_RESET 242347
`define SDR_GAIN_RESET 32
`define SDR_PEAK_INIT 32000

// Fixed frame lengths in data bytes
`define SDR_PARAM_BYTES 21
`define SDR_STATUS_BYTES 10

// Info upload payload
`define SDR_INFO_B0 4
`define SDR_INFO_B1 0
`define SDR_INFO_B2 0

// RX CIC decimation for rate codes 0..3
`define SDR_CIC_R0 160
`define SDR_CIC_R1 320
`define SDR_CIC_R2 640
`define SDR_CIC_R3 1280

`endif

//--- src/sdr_bus_pkg.sv
package sdr_bus_pkg;

	// Command byte sent by the MCU together with data_sync
	typedef enum logic [7:0]
	{
		CMD_BUS_TEST   = 8'd0,
		CMD_SET_PARAMS = 8'd1,
		CMD_GET_STATUS = 8'd2,
		CMD_TX_IQ      = 8'd3,
		CMD_RX_IQ      = 8'd4,
		CMD_RESET_ON   = 8'd5,
		CMD_RESET_OFF  = 8'd6,
		CMD_GET_INFO   = 8'd8 // Opcode 7 was flash access
	} bus_cmd_e;

	// Frame currently being walked by the command FSM
	typedef enum logic [2:0]
	{
		FR_IDLE,
		FR_ECHO,
		FR_PARAMS, // Download
		FR_STATUS, // Upload
		FR_TX_IQ, // Download
		FR_RX_IQ, // Upload, endless
		FR_INFO // Upload
	} frame_e;

endpackage

//--- src/bus_cmd_fsm.sv
`timescale 1ns/1ps
`include "sdr_bus_cfg.svh"

module bus_cmd_fsm
	import sdr_bus_pkg::*;
(
	input  logic       adcclk_in,
	input  logic       ADC_MINMAX_RESET,
	input  logic       data_sync,
	input  logic [7:0] bus_in,
	input  logic       rx2_en,
	input  logic       rx_last,
	output frame_e     frame,
	output logic [4:0] byte_idx,
	output logic       wr_stb,
	output logic       bus_oe,
	output logic       peak_clear,
	output logic       rx_capture,
	output logic       iq_rx_req,
	output logic       core_reset_n
);

	bus_cmd_e cmd;
	logic     last_byte;
	logic     rx_wrap;

	assign cmd = bus_cmd_e'(bus_in);

	// rx2_en may drop while the second receiver is being sent
	assign rx_wrap = rx_last || (!rx2_en && byte_idx > 5'd5);

	always_comb
	begin
		case (frame)
			FR_PARAMS: last_byte = (byte_idx == 5'(`SDR_PARAM_BYTES - 1));
			FR_STATUS: last_byte = (byte_idx == 5'(`SDR_STATUS_BYTES - 1));
			FR_TX_IQ:  last_byte = (byte_idx == 5'd5); // Q and I, 3 bytes each
			FR_INFO:   last_byte = (byte_idx == 5'd2);
			default:   last_byte = 1'b0;
		endcase
	end

	assign wr_stb = !data_sync && (frame == FR_PARAMS || frame == FR_TX_IQ);

	// Max low byte is on its way out, so the tracker may restart
	assign peak_clear = !data_sync && frame == FR_STATUS && byte_idx == 5'd4;

	// First capture on the command edge, then on every frame wrap
	assign rx_capture = data_sync ? (cmd == CMD_RX_IQ) : (frame == FR_RX_IQ && rx_wrap);

	always_ff @(posedge adcclk_in)
	begin
		if (ADC_MINMAX_RESET)
		begin
			frame        <= FR_IDLE;
			byte_idx     <= 5'd0;
			bus_oe       <= 1'b0;
			iq_rx_req    <= 1'b0;
			core_reset_n <= 1'b0;
		end
		else
		begin
			iq_rx_req <= rx_capture;
			if (data_sync)
			begin
				byte_idx <= 5'd0;
				bus_oe   <= 1'b0; // Abort whatever was running
				case (cmd)
					CMD_BUS_TEST:   frame <= FR_ECHO;
					CMD_SET_PARAMS: frame <= FR_PARAMS;
					CMD_GET_STATUS:
					begin
						frame  <= FR_STATUS;
						bus_oe <= 1'b1;
					end
					CMD_TX_IQ:      frame <= FR_TX_IQ;
					CMD_RX_IQ:
					begin
						frame  <= FR_RX_IQ;
						bus_oe <= 1'b1;
					end
					CMD_RESET_ON:
					begin
						frame        <= FR_IDLE;
						core_reset_n <= 1'b0;
					end
					CMD_RESET_OFF:
					begin
						frame        <= FR_IDLE;
						core_reset_n <= 1'b1;
					end
					CMD_GET_INFO:
					begin
						frame  <= FR_INFO;
						bus_oe <= 1'b1;
					end
					default:        frame <= FR_IDLE; // Unknown or flash
				endcase
			end
			else
			begin
				case (frame)
					FR_ECHO:
					begin
						// Even index captures, odd index drives back
						byte_idx <= {4'd0, ~byte_idx[0]};
						if (byte_idx[0])
							bus_oe <= 1'b1;
					end
					FR_RX_IQ:
						byte_idx <= rx_wrap ? 5'd0 : byte_idx + 5'd1;
					FR_PARAMS, FR_STATUS, FR_TX_IQ, FR_INFO:
					begin
						if (last_byte)
							frame <= FR_IDLE;
						else
							byte_idx <= byte_idx + 5'd1;
					end
					default:
						frame <= FR_IDLE;
				endcase
			end
		end
	end

endmodule

//--- src/param_regs.sv
`timescale 1ns/1ps
`include "sdr_bus_cfg.svh"

module param_regs
	import sdr_bus_pkg::*;
(
	input  logic                         adcclk_in,
	input  logic                         ADC_MINMAX_RESET,
	input  logic                         wr_stb,
	input  frame_e                       frame,
	input  logic [4:0]                   byte_idx,
	input  logic [7:0]                   bus_in,
	output logic [`SDR_NCO_W-1:0]        nco1_freq,
	output logic [`SDR_NCO_W-1:0]        nco2_freq,
	output logic [`SDR_NCO_W-1:0]        tx_nco_freq,
	output logic                         rx1_en,
	output logic                         rx2_en,
	output logic                         tx_en,
	output logic                         adc_dith,
	output logic                         adc_shdn,
	output logic                         adc_rand,
	output logic                         adc_pga,
	output logic                         preamp_en,
	output logic [7:0]                   cicfir_gain,
	output logic [7:0]                   tx_cicfir_gain,
	output logic [7:0]                   dac_gain,
	output logic signed [`SDR_ADC_W-1:0] adc_offset,
	output logic signed [7:0]            vcxo_correction,
	output logic [5:0]                   dac_ctrl,
	output logic [10:0]                  rx_cic_rate,
	output logic [1:0]                   dac_drv,
	output logic                         tx_clear
);

	logic wr_en;

	assign wr_en = wr_stb && frame == FR_PARAMS;

	// tx bit low in the flag byte flushes the TX sample
	assign tx_clear = wr_en && byte_idx == 5'd0 && !bus_in[2];

	always_ff @(posedge adcclk_in)
	begin
		if (ADC_MINMAX_RESET)
		begin
			nco1_freq       <= `SDR_NCO_RESET;
			nco2_freq       <= `SDR_NCO_RESET;
			tx_nco_freq     <= `SDR_NCO_RESET;
			{preamp_en, adc_pga, adc_rand, adc_shdn} <= 4'b0001; // ADC starts shut down
			{adc_dith, tx_en, rx2_en, rx1_en}        <= 4'b0001;
			cicfir_gain     <= 8'(`SDR_GAIN_RESET);
			tx_cicfir_gain  <= 8'(`SDR_GAIN_RESET);
			dac_gain        <= 8'd0;
			adc_offset      <= '0;
			vcxo_correction <= 8'sd0;
			dac_ctrl        <= 6'd0;
			rx_cic_rate     <= 11'(`SDR_CIC_R2);
			dac_drv         <= 2'b11;
		end
		else if (wr_en)
		begin
			case (byte_idx)
				5'd0: {preamp_en, adc_pga, adc_rand, adc_shdn,
					adc_dith, tx_en, rx2_en, rx1_en} <= bus_in;
				5'd1, 5'd2, 5'd3, 5'd4: nco1_freq <= {nco1_freq[`SDR_NCO_W-9:0], bus_in}; // MSB first
				5'd5, 5'd6, 5'd7, 5'd8: nco2_freq <= {nco2_freq[`SDR_NCO_W-9:0], bus_in};
				5'd9:  cicfir_gain    <= bus_in;
				5'd10: tx_cicfir_gain <= bus_in;
				5'd11: dac_gain       <= bus_in;
				5'd12, 5'd13: adc_offset <= {adc_offset[`SDR_ADC_W-9:0], bus_in};
				5'd14: vcxo_correction <= bus_in;
				5'd15:
				begin
					dac_ctrl <= bus_in[5:0];
					case (bus_in[7:6])
						2'd0:    rx_cic_rate <= 11'(`SDR_CIC_R0);
						2'd1:    rx_cic_rate <= 11'(`SDR_CIC_R1);
						2'd2:    rx_cic_rate <= 11'(`SDR_CIC_R2);
						default: rx_cic_rate <= 11'(`SDR_CIC_R3);
					endcase
				end
				5'd16, 5'd17, 5'd18, 5'd19: tx_nco_freq <= {tx_nco_freq[`SDR_NCO_W-9:0], bus_in};
				5'd20: dac_drv <= bus_in[1:0];
				default: ;
			endcase
		end
	end

endmodule

//--- src/adc_peak_detector.sv
`timescale 1ns/1ps
`include "sdr_bus_cfg.svh"

module adc_peak_detector
(
	input  logic                         adcclk_in,
	input  logic                         ADC_MINMAX_RESET,
	input  logic                         peak_clear,
	input  logic signed [`SDR_ADC_W-1:0] adc_in,
	output logic signed [`SDR_ADC_W-1:0] adc_min,
	output logic signed [`SDR_ADC_W-1:0] adc_max
);

	logic                         restart;
	logic signed [`SDR_ADC_W-1:0] min_base;
	logic signed [`SDR_ADC_W-1:0] max_base;

	assign restart = ADC_MINMAX_RESET || peak_clear;

	// Start from the opposite rails so the first sample always wins
	assign min_base = restart ? `SDR_ADC_W'(`SDR_PEAK_INIT) : adc_min;
	assign max_base = restart ? `SDR_ADC_W'(-`SDR_PEAK_INIT) : adc_max;

	always_ff @(posedge adcclk_in)
	begin
		adc_min <= (adc_in < min_base) ? adc_in : min_base;
		adc_max <= (adc_in > max_base) ? adc_in : max_base;
	end

endmodule

//--- src/tx_iq_assembler.sv
`timescale 1ns/1ps
`include "sdr_bus_cfg.svh"

module tx_iq_assembler
(
	input  logic                        adcclk_in,
	input  logic                        ADC_MINMAX_RESET,
	input  logic                        tx_frame,
	input  logic                        wr_stb,
	input  logic [4:0]                  byte_idx,
	input  logic [7:0]                  bus_in,
	input  logic                        tx_clear,
	output logic signed [`SDR_IQ_W-1:0] tx_i,
	output logic signed [`SDR_IQ_W-1:0] tx_q,
	output logic                        tx_iq_valid
);

	logic [`SDR_IQ_W-1:0] stage_q;
	logic [`SDR_IQ_W-9:0] stage_i; // Last I byte comes straight from the bus
	logic                 take;

	assign take = tx_frame && wr_stb;

	always_ff @(posedge adcclk_in)
	begin
		if (take && byte_idx < 5'd3)
			stage_q <= {stage_q[`SDR_IQ_W-9:0], bus_in}; // MSB first
		else if (take && byte_idx < 5'd5)
			stage_i <= {stage_i[`SDR_IQ_W-17:0], bus_in};
	end

	always_ff @(posedge adcclk_in)
	begin
		if (ADC_MINMAX_RESET)
		begin
			tx_i        <= '0;
			tx_q        <= '0;
			tx_iq_valid <= 1'b0;
		end
		else
		begin
			tx_iq_valid <= 1'b0;
			if (tx_clear)
			begin
				tx_i        <= '0;
				tx_q        <= '0;
				tx_iq_valid <= 1'b1;
			end
			else if (take && byte_idx == 5'd5)
			begin
				tx_q        <= stage_q;
				tx_i        <= {stage_i, bus_in};
				tx_iq_valid <= 1'b1; // Both halves land together
			end
		end
	end

endmodule

//--- src/readback_mux.sv
`timescale 1ns/1ps
`include "sdr_bus_cfg.svh"

module readback_mux
	import sdr_bus_pkg::*;
(
	input  logic                         adcclk_in,
	input  logic                         ADC_MINMAX_RESET,
	input  frame_e                       frame,
	input  logic [4:0]                   byte_idx,
	input  logic                         rx_capture,
	input  logic [7:0]                   bus_in,
	input  logic                         rx2_en,
	input  logic                         adc_otr,
	input  logic                         dac_otr,
	input  logic signed [`SDR_ADC_W-1:0] adc_min,
	input  logic signed [`SDR_ADC_W-1:0] adc_max,
	input  logic signed [`SDR_IQ_W-1:0]  vcxo_error,
	input  logic signed [`SDR_ADC_W-1:0] adc_raw,
	input  logic signed [`SDR_IQ_W-1:0]  rx1_i,
	input  logic signed [`SDR_IQ_W-1:0]  rx1_q,
	input  logic signed [`SDR_IQ_W-1:0]  rx2_i,
	input  logic signed [`SDR_IQ_W-1:0]  rx2_q,
	output logic [7:0]                   bus_out,
	output logic                         rx_last
);

	logic [`SDR_IQ_W-1:0] hold_rx1_i;
	logic [`SDR_IQ_W-1:0] hold_rx1_q;
	logic [`SDR_IQ_W-1:0] hold_rx2_i;
	logic [`SDR_IQ_W-1:0] hold_rx2_q;
	logic [7:0]           echo_byte;
	logic [79:0]          status_bytes;
	logic [95:0]          rx_bytes;
	logic [23:0]          info_bytes;

	// Byte 0 sits in the top slot of each vector
	assign status_bytes = {6'd0, dac_otr, adc_otr, adc_min, adc_max, vcxo_error, adc_raw};
	assign rx_bytes     = {hold_rx1_q, hold_rx1_i, hold_rx2_q, hold_rx2_i};
	assign info_bytes   = {8'(`SDR_INFO_B0), 8'(`SDR_INFO_B1), 8'(`SDR_INFO_B2)};

	assign rx_last = frame == FR_RX_IQ && byte_idx == (rx2_en ? 5'd11 : 5'd5);

	always_ff @(posedge adcclk_in)
	begin
		if (rx_capture)
		begin
			hold_rx1_i <= rx1_i;
			hold_rx1_q <= rx1_q;
			hold_rx2_i <= rx2_i;
			hold_rx2_q <= rx2_q;
		end
		if (frame == FR_ECHO && !byte_idx[0])
			echo_byte <= bus_in;
	end

	always_ff @(posedge adcclk_in)
	begin
		if (ADC_MINMAX_RESET)
			bus_out <= 8'd0;
		else
		begin
			case (frame)
				FR_STATUS: bus_out <= status_bytes[8 * (9 - int'(byte_idx)) +: 8];
				FR_RX_IQ:  bus_out <= rx_bytes[8 * (11 - int'(byte_idx)) +: 8];
				FR_INFO:   bus_out <= info_bytes[8 * (2 - int'(byte_idx)) +: 8];
				FR_ECHO:
				begin
					if (byte_idx[0])
						bus_out <= echo_byte;
				end
				default:   bus_out <= bus_out; // Keep last byte on the bus
			endcase
		end
	end

endmodule

//--- src/mcu_bus_top.sv
`timescale 1ns/1ps
`include "sdr_bus_cfg.svh"

module mcu_bus_top
	import sdr_bus_pkg::*;
(
	input  logic                         adcclk_in,
	input  logic                         ADC_MINMAX_RESET,
	input  logic                         data_sync,
	input  logic [7:0]                   bus_in,
	input  logic signed [`SDR_ADC_W-1:0] adc_in,
	input  logic signed [`SDR_ADC_W-1:0] adc_raw,
	input  logic                         adc_otr,
	input  logic                         dac_otr,
	input  logic signed [`SDR_IQ_W-1:0]  vcxo_error,
	input  logic signed [`SDR_IQ_W-1:0]  rx1_i,
	input  logic signed [`SDR_IQ_W-1:0]  rx1_q,
	input  logic signed [`SDR_IQ_W-1:0]  rx2_i,
	input  logic signed [`SDR_IQ_W-1:0]  rx2_q,
	output logic [7:0]                   bus_out,
	output logic                         bus_oe,
	output logic                         iq_rx_req,
	output logic                         core_reset_n,
	output logic [`SDR_NCO_W-1:0]        nco1_freq,
	output logic [`SDR_NCO_W-1:0]        nco2_freq,
	output logic [`SDR_NCO_W-1:0]        tx_nco_freq,
	output logic                         rx1_en,
	output logic                         rx2_en,
	output logic                         tx_en,
	output logic                         adc_dith,
	output logic                         adc_shdn,
	output logic                         adc_rand,
	output logic                         adc_pga,
	output logic                         preamp_en,
	output logic [7:0]                   cicfir_gain,
	output logic [7:0]                   tx_cicfir_gain,
	output logic [7:0]                   dac_gain,
	output logic signed [`SDR_ADC_W-1:0] adc_offset,
	output logic signed [7:0]            vcxo_correction,
	output logic [5:0]                   dac_ctrl,
	output logic [10:0]                  rx_cic_rate,
	output logic [1:0]                   dac_drv,
	output logic signed [`SDR_IQ_W-1:0]  tx_i,
	output logic signed [`SDR_IQ_W-1:0]  tx_q,
	output logic                         tx_iq_valid
);

	frame_e                       frame;
	logic [4:0]                   byte_idx;
	logic                         wr_stb;
	logic                         peak_clear;
	logic                         rx_capture;
	logic                         rx_last;
	logic                         tx_clear;
	logic                         tx_frame;
	logic signed [`SDR_ADC_W-1:0] adc_min;
	logic signed [`SDR_ADC_W-1:0] adc_max;

	assign tx_frame = (frame == FR_TX_IQ);

	bus_cmd_fsm u_fsm (.*);

	param_regs u_params (.*);

	adc_peak_detector u_peak (.*);

	tx_iq_assembler u_tx_iq (.*);

	readback_mux u_readback (.*);

endmodule

//--- sim/tb_mcu_bus.sv
`timescale 1ns/1ps

module tb_mcu_bus
	import sdr_bus_pkg::*;
;

	localparam int NROWS = 11;

	logic               adcclk_in;
	logic               ADC_MINMAX_RESET;
	logic               data_sync;
	logic [7:0]         bus_in;
	logic signed [15:0] adc_in;
	logic signed [15:0] adc_raw;
	logic               adc_otr;
	logic               dac_otr;
	logic signed [23:0] vcxo_error;
	logic signed [23:0] rx1_i;
	logic signed [23:0] rx1_q;
	logic signed [23:0] rx2_i;
	logic signed [23:0] rx2_q;
	logic [7:0]         bus_out;
	logic               bus_oe;
	logic               iq_rx_req;
	logic               core_reset_n;
	logic [31:0]        nco1_freq;
	logic [31:0]        nco2_freq;
	logic [31:0]        tx_nco_freq;
	logic               rx1_en;
	logic               rx2_en;
	logic               tx_en;
	logic               adc_dith;
	logic               adc_shdn;
	logic               adc_rand;
	logic               adc_pga;
	logic               preamp_en;
	logic [7:0]         cicfir_gain;
	logic [7:0]         tx_cicfir_gain;
	logic [7:0]         dac_gain;
	logic signed [15:0] adc_offset;
	logic signed [7:0]  vcxo_correction;
	logic [5:0]         dac_ctrl;
	logic [10:0]        rx_cic_rate;
	logic [1:0]         dac_drv;
	logic signed [23:0] tx_i;
	logic signed [23:0] tx_q;
	logic               tx_iq_valid;

	// Stimulus table, one row per command
	logic [7:0]         row_cmd [NROWS];
	int                 row_len [NROWS]; // Bytes, or bytes per RX frame
	int                 row_reps [NROWS]; // RX frames
	int                 row_adc [NROWS]; // ADC sequence before the row, 0 for none
	logic [1:0]         row_flags [NROWS];
	logic [23:0]        row_vcxo [NROWS];
	logic [15:0]        row_raw [NROWS];
	logic [7:0]         row_data [NROWS][24];
	logic signed [15:0] seqs [2][6];
	logic [23:0]        smp [4]; // q1, i1, q2, i2 on the inputs
	logic [23:0]        held [4];

	mcu_bus_top dut (.*);

	always #20 adcclk_in = ~adcclk_in;

	initial
	begin
		#(NROWS * 30 * 40);
		$display("Timeout: the bus transfers did not complete in time");
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

	task automatic verify(input logic ok, input string what);
		assert (ok)
		else
		begin
			$display("Mismatch at %0d ns: %s", $time, what);
			$display("Regression failed");
			$fatal(1, "check failed");
		end
	endtask

	function automatic logic [10:0] cic_rate_of(input logic [1:0] code);
		case (code)
			2'd0:    return 11'd160;
			2'd1:    return 11'd320;
			2'd2:    return 11'd640;
			default: return 11'd1280;
		endcase
	endfunction

	task automatic add_row(input int r, input logic [7:0] cmd, input int len, input int reps,
		input int adc);
		row_cmd[r]   = cmd;
		row_len[r]   = len;
		row_reps[r]  = reps;
		row_adc[r]   = adc;
		row_flags[r] = 2'($urandom);
		row_vcxo[r]  = 24'($urandom);
		row_raw[r]   = 16'($urandom);
		for (int i = 0; i < 24; i++)
			row_data[r][i] = 8'($urandom);
	endtask

	task automatic expect_status(input int r);
		logic signed [15:0] mn;
		logic signed [15:0] mx;
		logic [79:0]        word;
		mn = seqs[row_adc[r] - 1][0];
		mx = mn;
		for (int k = 1; k < 6; k++)
		begin
			if (seqs[row_adc[r] - 1][k] < mn)
				mn = seqs[row_adc[r] - 1][k];
			if (seqs[row_adc[r] - 1][k] > mx)
				mx = seqs[row_adc[r] - 1][k];
		end
		word = {6'd0, row_flags[r], mn, mx, row_vcxo[r], row_raw[r]};
		for (int i = 0; i < 10; i++)
			row_data[r][i] = word[8 * (9 - i) +: 8];
	endtask

	task automatic build_table();
		seqs[0] = '{-16'sd1000, 16'sd5000, 16'sd200, -16'sd20000, 16'sd300, 16'sd100};
		seqs[1] = '{16'sd100, -16'sd50, 16'sd250, 16'sd10, 16'sd60, 16'sd10}; // Narrower
		add_row(0, CMD_RESET_OFF, 0, 0, 0);
		add_row(1, CMD_RESET_ON, 0, 0, 0);
		add_row(2, CMD_TX_IQ, 6, 0, 0);
		add_row(3, CMD_SET_PARAMS, 21, 0, 0);
		row_data[3][0][2:1] = 2'b00; // tx off, rx2 off
		add_row(4, CMD_GET_STATUS, 10, 0, 1);
		expect_status(4);
		add_row(5, CMD_GET_STATUS, 10, 0, 2);
		expect_status(5);
		add_row(6, CMD_RX_IQ, 6, 3, 0);
		add_row(7, CMD_SET_PARAMS, 21, 0, 0);
		row_data[7][0][2:1] = 2'b11;
		add_row(8, CMD_RX_IQ, 12, 2, 0);
		add_row(9, CMD_BUS_TEST, 4, 0, 0);
		add_row(10, CMD_GET_INFO, 3, 0, 0);
		row_data[10][0] = 8'd4;
		row_data[10][1] = 8'd0;
		row_data[10][2] = 8'd0;
	endtask

	task automatic new_rx_inputs();
		for (int k = 0; k < 4; k++)
			smp[k] = 24'($urandom);
		rx1_q = smp[0];
		rx1_i = smp[1];
		rx2_q = smp[2];
		rx2_i = smp[3];
	endtask

	// Leaves the caller on the falling edge after the command edge
	task automatic send_cmd(input logic [7:0] cmd);
		data_sync = 1'b1;
		bus_in    = cmd;
		@(negedge adcclk_in);
		data_sync = 1'b0;
		bus_in    = 8'd0;
	endtask

	task automatic check_params(input int r);
		verify({preamp_en, adc_pga, adc_rand, adc_shdn, adc_dith, tx_en, rx2_en, rx1_en}
			== row_data[r][0], "flag bits");
		verify(nco1_freq == {row_data[r][1], row_data[r][2], row_data[r][3], row_data[r][4]},
			"nco1_freq");
		verify(nco2_freq == {row_data[r][5], row_data[r][6], row_data[r][7], row_data[r][8]},
			"nco2_freq");
		verify(cicfir_gain == row_data[r][9], "cicfir_gain");
		verify(tx_cicfir_gain == row_data[r][10], "tx_cicfir_gain");
		verify(dac_gain == row_data[r][11], "dac_gain");
		verify(adc_offset == {row_data[r][12], row_data[r][13]}, "adc_offset");
		verify(vcxo_correction == row_data[r][14], "vcxo_correction");
		verify(dac_ctrl == row_data[r][15][5:0], "dac_ctrl");
		verify(rx_cic_rate == cic_rate_of(row_data[r][15][7:6]), "rx_cic_rate");
		verify(tx_nco_freq == {row_data[r][16], row_data[r][17], row_data[r][18],
			row_data[r][19]}, "tx_nco_freq");
		verify(dac_drv == row_data[r][20][1:0], "dac_drv");
	endtask

	task automatic run_row(input int r);
		logic [7:0] b;
		if (row_adc[r] != 0)
		begin
			for (int k = 0; k < 6; k++)
			begin
				adc_in = seqs[row_adc[r] - 1][k];
				@(negedge adcclk_in);
			end
		end
		{dac_otr, adc_otr} = row_flags[r];
		vcxo_error = row_vcxo[r];
		adc_raw    = row_raw[r];
		if (row_cmd[r] == CMD_RX_IQ)
		begin
			verify(rx2_en == (row_len[r] == 12), "rx2_en before RX upload");
			new_rx_inputs();
		end
		send_cmd(row_cmd[r]);
		case (row_cmd[r])
			CMD_RESET_OFF: verify(core_reset_n == 1'b1, "core_reset_n after RESET_OFF");
			CMD_RESET_ON:  verify(core_reset_n == 1'b0, "core_reset_n after RESET_ON");
			CMD_TX_IQ, CMD_SET_PARAMS:
			begin
				for (int i = 0; i < row_len[r]; i++)
				begin
					bus_in = row_data[r][i];
					@(negedge adcclk_in);
					if (row_cmd[r] == CMD_SET_PARAMS && !row_data[r][0][2] && i < 2)
						verify(tx_iq_valid == (i == 0) && tx_i == 24'd0 && tx_q == 24'd0,
							"TX clear on parameter byte 0");
					if (row_cmd[r] == CMD_TX_IQ && i == 4)
						verify(!tx_iq_valid, "tx_iq_valid early");
				end
				if (row_cmd[r] == CMD_SET_PARAMS)
					check_params(r);
				else
				begin
					verify(tx_iq_valid, "tx_iq_valid after sixth byte");
					verify(tx_q == {row_data[r][0], row_data[r][1], row_data[r][2]}, "tx_q");
					verify(tx_i == {row_data[r][3], row_data[r][4], row_data[r][5]}, "tx_i");
					@(negedge adcclk_in);
					verify(!tx_iq_valid, "tx_iq_valid longer than one cycle");
				end
			end
			CMD_RX_IQ:
			begin
				verify(iq_rx_req, "iq_rx_req after RX command");
				for (int f = 0; f < row_reps[r]; f++)
				begin
					held = smp;
					for (int j = 0; j < row_len[r]; j++)
					begin
						@(negedge adcclk_in);
						b = held[j / 3][8 * (2 - j % 3) +: 8];
						verify(bus_oe && bus_out == b, "RX IQ byte");
						verify(iq_rx_req == (j == row_len[r] - 1), "iq_rx_req once per frame");
						if (j == 0)
							new_rx_inputs(); // Inputs move, held samples must not
					end
				end
			end
			CMD_BUS_TEST:
			begin
				for (int k = 0; k < row_len[r]; k++)
				begin
					bus_in = row_data[r][k];
					@(negedge adcclk_in);
					if (k == 0)
						verify(!bus_oe, "bus_oe before first echo");
					bus_in = ~row_data[r][k];
					@(negedge adcclk_in);
					verify(bus_oe && bus_out == row_data[r][k], "echo byte");
				end
			end
			default:
			begin
				for (int i = 0; i < row_len[r]; i++)
				begin
					@(negedge adcclk_in);
					verify(bus_oe && bus_out == row_data[r][i], "upload byte");
				end
			end
		endcase
		@(negedge adcclk_in);
	endtask

	initial
	begin
		adcclk_in        = 1'b0;
		ADC_MINMAX_RESET = 1'b1;
		data_sync        = 1'b0;
		bus_in           = 8'd0;
		adc_in           = 16'sd0;
		adc_raw          = 16'sd0;
		adc_otr          = 1'b0;
		dac_otr          = 1'b0;
		vcxo_error       = 24'sd0;
		rx1_i            = 24'sd0;
		rx1_q            = 24'sd0;
		rx2_i            = 24'sd0;
		rx2_q            = 24'sd0;
		void'($urandom(32'h462b));
		build_table();
		repeat (2) @(posedge adcclk_in);
		@(negedge adcclk_in);
		ADC_MINMAX_RESET = 1'b0;
		verify(nco1_freq == 32'd242347 && nco2_freq == 32'd242347
			&& tx_nco_freq == 32'd242347, "NCO reset values");
		verify(cicfir_gain == 8'd32 && tx_cicfir_gain == 8'd32, "gain reset values");
		verify(rx_cic_rate == 11'd640, "CIC rate reset value");
		verify(!bus_oe && !tx_iq_valid && !core_reset_n && !iq_rx_req, "outputs after reset");
		for (int r = 0; r < NROWS; r++)
			run_row(r);
		$display("Regression passed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+src
src/sdr_bus_pkg.sv
src/bus_cmd_fsm.sv
src/param_regs.sv
src/adc_peak_detector.sv
src/tx_iq_assembler.sv
src/readback_mux.sv
src/mcu_bus_top.sv
sim/tb_mcu_bus.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -f vlog.f --top-module tb_mcu_bus -o tb_mcu_bus

./obj_dir/tb_mcu_bus
